// ==== design/erx_regmap.svh ====
//##########################################################################
// register word addresses, compared against mi_addr[RFAW+1:2]
//##########################################################################
`ifndef ERX_REGMAP_SVH
`define ERX_REGMAP_SVH
`default_nettype none

// word offsets, byte address = word * 4
`define ERX_CFG      0
`define ERX_STATUS   1
`define ERX_GPIO     2
`define ERX_OFFSET   3
`define ERX_TESTDATA 4

`default_nettype wire
`endif

// ==== design/erx_pkg.sv ====
//##########################################################################
// shared types and constants for the link receive path
// import into any module that touches packets, status or the mi bus
//##########################################################################
`default_nettype none

package erx_pkg;

   //########################################################################
   // widths that carry meaning
   //########################################################################
   typedef logic [103:0] erx_packet_t;   // full link packet
   typedef logic [31:0]  erx_addr_t;     // destination address
   typedef logic [31:0]  erx_data_t;     // data word, also mi bus word
   typedef logic [15:0]  erx_status_t;   // sticky status bits
   typedef logic [14:0]  mi_addr_t;      // byte address on mi bus

   // packet field positions
   localparam int PKT_ADDR_LSB = 8;      // dst addr in bits 39..8
   localparam int PKT_DATA_LSB = 40;     // data in bits 71..40

   // status event bits
   localparam int STAT_DROP = 0;         // consumed in test mode
   localparam int STAT_FWD  = 1;         // sent downstream

   //########################################################################
   // remap modes, 3 falls through to none
   //########################################################################
   localparam logic [1:0] REMAP_NONE    = 2'd0;
   localparam logic [1:0] REMAP_STATIC  = 2'd1;
   localparam logic [1:0] REMAP_DYNAMIC = 2'd2;

endpackage

`default_nettype wire

// ==== design/erx_cfg_if.sv ====
//##########################################################################
// config fields from the register file out to remap and dispatch
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

interface erx_cfg_if import erx_pkg::*; ();

   logic        test_mode;       // drop all rx traffic
   logic        mmu_enable;      // no mmu here, bit only
   logic [1:0]  remap_mode;
   logic [11:0] remap_sel;       // static remap bit selects
   logic [11:0] remap_pattern;   // static remap value
   logic        mailbox_irq_en;  // no mailbox here, bit only
   erx_addr_t   remap_base;      // dynamic remap offset

   // register file drives everything
   modport cfg_src (
      output test_mode, mmu_enable, remap_mode, remap_sel,
             remap_pattern, mailbox_irq_en, remap_base
   );

   modport remap_sink (
      input remap_mode, remap_sel, remap_pattern, remap_base
   );

   modport disp_sink (input test_mode);

endinterface

`default_nettype wire

// ==== design/erx_cfg.sv ====
//##########################################################################
// rx register file on the mi bus, writes land next edge, reads one cycle
// later on mi_dout; also counts data words of every incoming packet
//##########################################################################
`timescale 1ns/1ns
`include "erx_regmap.svh"
`default_nettype none

module erx_cfg import erx_pkg::*; #(
   parameter int RFAW = 6              // word address bits
) (
   input  logic         clk,
   input  logic         nreset,
   // mi bus
   input  logic         mi_en,
   input  logic         mi_we,
   input  mi_addr_t     mi_addr,
   input  erx_data_t    mi_din,
   output erx_data_t    mi_dout,
   // incoming traffic, for testdata sum
   input  logic         rx_access,
   input  erx_packet_t  rx_packet,
   // status inputs
   input  logic [8:0]   gpio_datain,
   input  erx_status_t  status_evt,
   erx_cfg_if.cfg_src   cfg
);

   logic [RFAW-1:0] reg_addr;        // word address
   logic            mi_wr;
   logic            mi_rd;
   logic            cfg_we;
   logic            status_we;
   logic            offset_we;
   logic            testdata_we;

   erx_data_t       cfg_reg;
   erx_status_t     status_reg;
   logic [8:0]      gpio_reg;
   erx_addr_t       offset_reg;
   erx_data_t       testdata_reg;

   //########################################################################
   // decode
   //########################################################################
   assign reg_addr = mi_addr[RFAW+1:2];  // byte to word
   assign mi_wr    = mi_en & mi_we;
   assign mi_rd    = mi_en & ~mi_we;

   assign cfg_we      = mi_wr & (reg_addr == RFAW'(`ERX_CFG));
   assign status_we   = mi_wr & (reg_addr == RFAW'(`ERX_STATUS));
   assign offset_we   = mi_wr & (reg_addr == RFAW'(`ERX_OFFSET));
   assign testdata_we = mi_wr & (reg_addr == RFAW'(`ERX_TESTDATA));

   //########################################################################
   // registers
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg_reg      <= '0;
         status_reg   <= '0;
         gpio_reg     <= '0;
         offset_reg   <= '0;
         testdata_reg <= '0;
      end else begin
         if (cfg_we)
            cfg_reg <= mi_din;
         if (offset_we)
            offset_reg <= mi_din;
         gpio_reg <= gpio_datain;         // free-running sample

         // sticky, write loads over the events
         if (status_we)
            status_reg <= mi_din[15:0];
         else
            status_reg <= status_reg | status_evt;

         // running sum of rx data words, in any mode
         if (testdata_we)
            testdata_reg <= mi_din;
         else if (rx_access)
            testdata_reg <= testdata_reg + rx_packet[PKT_DATA_LSB +: 32];
      end
   end

   // cfg fields out
   assign cfg.test_mode      = cfg_reg[0];
   assign cfg.mmu_enable     = cfg_reg[1];
   assign cfg.remap_mode     = cfg_reg[3:2];
   assign cfg.remap_sel      = cfg_reg[15:4];
   assign cfg.remap_pattern  = cfg_reg[27:16];
   assign cfg.mailbox_irq_en = cfg_reg[28];
   assign cfg.remap_base     = offset_reg;

   //########################################################################
   // readback, registered, holds between reads
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         mi_dout <= '0;
      end else if (mi_rd) begin
         case (reg_addr)
            RFAW'(`ERX_CFG):      mi_dout <= cfg_reg;
            RFAW'(`ERX_STATUS):   mi_dout <= {16'b0, status_reg};
            RFAW'(`ERX_GPIO):     mi_dout <= {23'b0, gpio_reg};
            RFAW'(`ERX_OFFSET):   mi_dout <= offset_reg;
            RFAW'(`ERX_TESTDATA): mi_dout <= testdata_reg;
            default:              mi_dout <= '0;  // unused reads zero
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/erx_remap.sv ====
//##########################################################################
// destination address rewrite, one register stage, a packet every cycle
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module erx_remap import erx_pkg::*; (
   input  logic          clk,
   input  logic          nreset,
   input  logic          rx_access,
   input  erx_packet_t   rx_packet,
   erx_cfg_if.remap_sink cfg,
   output logic          rm_access,
   output erx_packet_t   rm_packet
);

   erx_addr_t   dst_addr;    // as received
   erx_addr_t   new_addr;    // after remap
   erx_packet_t new_packet;

   assign dst_addr = rx_packet[PKT_ADDR_LSB +: 32];

   always_comb begin
      case (cfg.remap_mode)
         // upper 12 bits: pattern where sel set, own bit elsewhere
         REMAP_STATIC:  new_addr = {(cfg.remap_pattern & cfg.remap_sel) |
                                    (dst_addr[31:20] & ~cfg.remap_sel),
                                    dst_addr[19:0]};
         REMAP_DYNAMIC: new_addr = dst_addr + cfg.remap_base;  // wraps
         default:       new_addr = dst_addr;                   // none, 3
      endcase
      new_packet = rx_packet;                       // rest passes through
      new_packet[PKT_ADDR_LSB +: 32] = new_addr;
   end

   // valid bit
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rm_access <= 1'b0;
      else
         rm_access <= rx_access;
   end

   // payload, loads only on a packet
   always_ff @(posedge clk) begin
      if (rx_access)
         rm_packet <= new_packet;
   end

endmodule

`default_nettype wire

// ==== design/erx_dispatch.sv ====
//##########################################################################
// packet FIFO and send side: drops in test mode, else forwards on credit
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module erx_dispatch import erx_pkg::*; #(
   parameter int FIFO_DEPTH  = 4,      // = input credits
   parameter int OUT_CREDITS = 2       // downstream credits at reset
) (
   input  logic          clk,
   input  logic          nreset,
   input  logic          rm_access,
   input  erx_packet_t   rm_packet,
   erx_cfg_if.disp_sink  cfg,
   output logic          tx_access,
   output erx_packet_t   tx_packet,
   input  logic          tx_credit,
   output logic          rx_credit,
   output erx_status_t   status_evt
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);
   localparam int OW = $clog2(OUT_CREDITS + 1);

   erx_packet_t   fifo_mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] fifo_cnt;   // packets queued
   logic [OW-1:0] out_cnt;    // output credits held
   logic          push;
   logic          pop;
   logic          drop;

   assign drop = rm_access & cfg.test_mode;
   assign push = rm_access & ~cfg.test_mode;
   // a drop owns this cycle's credit return, the send waits one cycle
   assign tx_access = (out_cnt != '0) & (fifo_cnt != '0) & ~drop;
   assign pop       = tx_access;
   assign tx_packet = fifo_mem[rd_ptr];    // head of queue

   always_ff @(posedge clk) begin
      if (push)
         fifo_mem[wr_ptr] <= rm_packet;
   end

   //########################################################################
   // pointers and counters
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fifo_cnt  <= '0;
         out_cnt   <= OW'(OUT_CREDITS);
         rx_credit <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
            2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
            default: fifo_cnt <= fifo_cnt;
         endcase
         case ({tx_credit, tx_access})
            2'b10:   out_cnt <= out_cnt + 1'b1;   // consumer returns one
            2'b01:   out_cnt <= out_cnt - 1'b1;   // spent on a send
            default: out_cnt <= out_cnt;
         endcase
         rx_credit <= drop | pop;                 // one slot freed
      end
   end

   always_comb begin
      status_evt            = '0;
      status_evt[STAT_DROP] = drop;
      status_evt[STAT_FWD]  = tx_access;
   end

endmodule

`default_nettype wire

// ==== design/erx_top.sv ====
//##########################################################################
// link receive top, register file and remap side by side, then dispatch
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module erx_top import erx_pkg::*; #(
   parameter int RFAW        = 6,
   parameter int FIFO_DEPTH  = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic        clk,
   input  logic        nreset,
   // mi bus
   input  logic        mi_en,
   input  logic        mi_we,
   input  mi_addr_t    mi_addr,
   input  erx_data_t   mi_din,
   output erx_data_t   mi_dout,
   // link in
   input  logic        rx_access,
   input  erx_packet_t rx_packet,
   output logic        rx_credit,
   input  logic [8:0]  gpio_datain,
   // downstream
   output logic        tx_access,
   output erx_packet_t tx_packet,
   input  logic        tx_credit
);

   logic        rm_access;
   erx_packet_t rm_packet;
   erx_status_t status_evt;

   erx_cfg_if cfg_if ();

   erx_cfg #(.RFAW(RFAW)) erx_cfg_i (
      .clk, .nreset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .rx_access, .rx_packet, .gpio_datain, .status_evt,
      .cfg (cfg_if.cfg_src)
   );

   erx_remap erx_remap_i (
      .clk, .nreset, .rx_access, .rx_packet,
      .cfg (cfg_if.remap_sink),
      .rm_access, .rm_packet
   );

   erx_dispatch #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) erx_dispatch_i (
      .clk, .nreset, .rm_access, .rm_packet,
      .cfg (cfg_if.disp_sink),
      .tx_access, .tx_packet, .tx_credit, .rx_credit, .status_evt
   );

endmodule

`default_nettype wire

// ==== tb/erx_checker.sv ====
//##########################################################################
// credit protocol assertions, bound into every erx_dispatch instance
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module erx_checker #(
   parameter int FIFO_DEPTH  = 4,
   parameter int OUT_CREDITS = 2
) (
   input logic                               clk,
   input logic                               nreset,
   input logic                               tx_access,
   input logic                               tx_credit,
   input logic                               rx_credit,
   input logic                               push,
   input logic                               pop,
   input logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_cnt
);

   localparam int CW = $clog2(FIFO_DEPTH + 1);

   int credits_left;   // output credits, from the handshakes alone

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         credits_left <= OUT_CREDITS;
      else
         credits_left <= credits_left + int'(tx_credit) - int'(tx_access);
   end

   // a send spends a credit that must exist
   tx_needs_credit: assert property (@(posedge clk) disable iff (!nreset)
      tx_access |-> credits_left > 0)
      else $error("tx_access with no output credit left");

   // occupancy bound, and no push into a full fifo without a pop
   fifo_in_range: assert property (@(posedge clk) disable iff (!nreset)
      fifo_cnt <= CW'(FIFO_DEPTH))
      else $error("fifo count above its depth");
   no_push_when_full: assert property (@(posedge clk) disable iff (!nreset)
      (push && !pop) |-> fifo_cnt < CW'(FIFO_DEPTH))
      else $error("fifo overflow on push");

   // both handshakes quiet while held in reset
   quiet_in_reset: assert property (@(posedge clk)
      !nreset |-> (!rx_credit && !tx_access))
      else $error("credit or send active during reset");

endmodule

bind erx_dispatch erx_checker #(
   .FIFO_DEPTH (FIFO_DEPTH),
   .OUT_CREDITS(OUT_CREDITS)
) erx_checker_i (
   .clk, .nreset, .tx_access, .tx_credit, .rx_credit, .push, .pop, .fifo_cnt
);

`default_nettype wire

// ==== tb/erx_tb.sv ====
//##########################################################################
// directed tests for the link receive top: registers, remap, credits and
// test mode; one line per test, then a summary and the result line
//##########################################################################
`timescale 1ns/1ns
`include "erx_regmap.svh"
`default_nettype none

module erx_tb import erx_pkg::*; ();

   localparam int RFAW            = 6;
   localparam int FIFO_DEPTH      = 4;
   localparam int OUT_CREDITS     = 2;
   localparam int SEED            = 61152;
   localparam int RESET_CYCLES    = 10;
   localparam int NUM_TESTS       = 5;
   localparam int MAX_TEST_CYCLES = 400;   // longest test, with margin

   logic        clk;
   logic        nreset;
   logic        mi_en;
   logic        mi_we;
   mi_addr_t    mi_addr;
   erx_data_t   mi_din;
   erx_data_t   mi_dout;
   logic        rx_access;
   erx_packet_t rx_packet;
   logic        rx_credit;
   logic [8:0]  gpio_datain;
   logic        tx_access;
   erx_packet_t tx_packet;
   logic        tx_credit;

   erx_packet_t tx_q [$];          // every packet seen on tx
   int          rx_credit_cnt = 0;
   int          credits_sent  = 0; // tx credits handed back
   int          credit_grant  = 0; // manual credit target
   bit          auto_credit   = 1'b1;
   int          rx_sent       = 0;
   int          errors        = 0;
   int          checks        = 0;
   int          failed_tests  = 0;
   int          seed_init;

   erx_top #(.RFAW(RFAW), .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) erx_top_i (
      .clk, .nreset, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .rx_access, .rx_packet, .rx_credit, .gpio_datain,
      .tx_access, .tx_packet, .tx_credit
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //########################################################################
   // downstream consumer, samples at negedge, returns credits after posedge
   //########################################################################
   initial begin
      bit give;
      tx_credit = 1'b0;
      forever begin
         @(negedge clk);
         if (tx_access)
            tx_q.push_back(tx_packet);
         if (rx_credit)
            rx_credit_cnt++;
         give = credits_sent < (auto_credit ? tx_q.size() : credit_grant);
         if (give)
            credits_sent++;
         @(posedge clk);
         #1 tx_credit = give;
      end
   end

   initial begin
      #((RESET_CYCLES + NUM_TESTS * MAX_TEST_CYCLES) * 10);
      $display("watchdog: run took longer than its time limit");
      $display("Result: FAILED");
      $finish;
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic tick_n(int n);
      repeat (n) tick();
   endtask

   // mi bus, write lands at the edge, read data valid after the edge
   task automatic mi_write(int word, erx_data_t data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = mi_addr_t'(word * 4);
      mi_din  = data;
      tick();
      mi_en = 1'b0;
      mi_we = 1'b0;
   endtask

   task automatic mi_read(int word, output erx_data_t data);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = mi_addr_t'(word * 4);
      tick();
      mi_en = 1'b0;
      data  = mi_dout;
   endtask

   //########################################################################
   // compare tasks
   //########################################################################
   task automatic check_data(string name, erx_data_t exp, erx_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(string name, erx_addr_t exp, erx_addr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected addr %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_status(string name, erx_status_t exp, erx_status_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected status %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_packet(string name, erx_packet_t exp, erx_packet_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected packet %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_test(string name, int err0);
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   function automatic erx_packet_t random_packet();
      erx_packet_t p;
      p[31:0]   = $urandom();
      p[63:32]  = $urandom();
      p[95:64]  = $urandom();
      p[103:96] = 8'($urandom());
      return p;
   endfunction

   // expected destination after remap, bit by bit from the mode rules
   function automatic erx_addr_t remapped_addr(logic [1:0] mode, erx_addr_t addr,
                                              logic [11:0] sel, logic [11:0] pat,
                                              erx_addr_t base);
      erx_addr_t a;
      a = addr;
      if (mode == 2'd1) begin
         for (int i = 0; i < 12; i++)
            if (sel[i])
               a[20+i] = pat[i];
      end else if (mode == 2'd2) begin
         a = addr + base;
      end
      return a;
   endfunction

   //########################################################################
   // traffic helpers
   //########################################################################
   task automatic send_packet(erx_packet_t p);
      int waited;
      waited = 0;
      while (rx_sent - rx_credit_cnt >= FIFO_DEPTH && waited < MAX_TEST_CYCLES) begin
         tick();
         waited++;
      end
      if (waited >= MAX_TEST_CYCLES) begin
         errors++;
         $display("no input credit came back within %0d cycles", MAX_TEST_CYCLES);
      end
      rx_access = 1'b1;
      rx_packet = p;
      rx_sent++;
      tick();
      rx_access = 1'b0;
   endtask

   task automatic wait_tx(int count, string name);
      int waited;
      waited = 0;
      while (tx_q.size() < count && waited < MAX_TEST_CYCLES) begin
         tick();
         waited++;
      end
      if (tx_q.size() < count) begin
         errors++;
         $display("%s: timed out waiting for packet %0d on tx", name, count);
      end
   endtask

   task automatic wait_rx_credits(int count, string name);
      int waited;
      waited = 0;
      while (rx_credit_cnt < count && waited < MAX_TEST_CYCLES) begin
         tick();
         waited++;
      end
      if (rx_credit_cnt < count) begin
         errors++;
         $display("%s: timed out waiting for input credit %0d", name, count);
      end
   endtask

   // compare tx_q from first onwards against sent, addresses remapped
   task automatic compare_tx(string name, int first, erx_packet_t sent [$],
                             logic [1:0] mode, logic [11:0] sel,
                             logic [11:0] pat, erx_addr_t base);
      erx_packet_t exp;
      erx_packet_t got;
      erx_addr_t   a;
      for (int i = 0; i < sent.size(); i++) begin
         if (first + i < tx_q.size()) begin
            got = tx_q[first + i];
            exp = sent[i];
            a   = remapped_addr(mode, exp[PKT_ADDR_LSB +: 32], sel, pat, base);
            exp[PKT_ADDR_LSB +: 32] = a;
            check_addr(name, a, got[PKT_ADDR_LSB +: 32]);
            check_packet(name, exp, got);
         end
      end
   endtask

   task automatic send_and_check(string name, int n, logic [1:0] mode,
                                 logic [11:0] sel, logic [11:0] pat,
                                 erx_addr_t base);
      erx_packet_t sent [$];
      erx_packet_t p;
      int          first;
      first = tx_q.size();
      for (int i = 0; i < n; i++) begin
         p = random_packet();
         sent.push_back(p);
         send_packet(p);
      end
      wait_tx(first + n, name);
      tick_n(4);
      if (tx_q.size() != first + n) begin
         errors++;
         $display("%s: %0d packets on tx, %0d sent", name, tx_q.size() - first, n);
      end
      compare_tx(name, first, sent, mode, sel, pat, base);
   endtask

   //########################################################################
   // directed tests
   //########################################################################
   task automatic reg_access_test();
      int          err0;
      erx_data_t   v;
      erx_data_t   rd;
      logic [8:0]  g;
      err0 = errors;
      v = $urandom();
      mi_write(`ERX_CFG, v);
      mi_read(`ERX_CFG, rd);
      check_data("reg cfg", v, rd);
      mi_write(`ERX_CFG, '0);
      v = $urandom();
      mi_write(`ERX_OFFSET, v);
      mi_read(`ERX_OFFSET, rd);
      check_data("reg offset", v, rd);
      v = $urandom();
      mi_write(`ERX_STATUS, v);             // upper half not stored
      mi_read(`ERX_STATUS, rd);
      check_status("reg status", v[15:0], rd[15:0]);
      check_data("reg status upper", '0, {rd[31:16], 16'h0});
      g = 9'($urandom());
      gpio_datain = g;
      tick_n(2);                            // sampled every cycle
      mi_read(`ERX_GPIO, rd);
      check_data("reg gpio", {23'b0, g}, rd);
      mi_read(5, rd);
      check_data("reg unused 5", '0, rd);
      mi_read(`ERX_OFFSET, rd);             // nonzero back on mi_dout
      mi_read((1 << RFAW) - 1, rd);
      check_data("reg unused top", '0, rd);
      report_test("reg_access", err0);
   endtask

   task automatic pass_through_test();
      int          err0;
      erx_data_t   rd;
      erx_status_t exp;
      err0 = errors;
      mi_write(`ERX_CFG, '0);
      mi_write(`ERX_STATUS, '0);
      send_and_check("pass_through", 8, REMAP_NONE, '0, '0, '0);
      mi_read(`ERX_STATUS, rd);
      exp = '0;
      exp[STAT_FWD] = 1'b1;
      check_status("pass_through status", exp, rd[15:0]);
      report_test("pass_through", err0);
   endtask

   task automatic remap_test();
      int          err0;
      logic [11:0] sel;
      logic [11:0] pat;
      erx_addr_t   base;
      err0 = errors;
      sel = 12'($urandom());
      pat = 12'($urandom());
      mi_write(`ERX_CFG, {4'b0, pat, sel, REMAP_STATIC, 2'b00});
      send_and_check("remap_static", 6, REMAP_STATIC, sel, pat, '0);
      base = $urandom();
      mi_write(`ERX_OFFSET, base);
      mi_write(`ERX_CFG, {28'b0, REMAP_DYNAMIC, 2'b00});
      send_and_check("remap_dynamic", 6, REMAP_DYNAMIC, '0, '0, base);
      mi_write(`ERX_CFG, {28'b0, 2'd3, 2'b00});   // reserved, as none
      send_and_check("remap_mode3", 4, 2'd3, '0, '0, base);
      mi_write(`ERX_CFG, '0);
      report_test("remap", err0);
   endtask

   task automatic back_pressure_test();
      int          err0;
      int          first;
      int          cbase;
      erx_packet_t sent [$];
      erx_packet_t p;
      err0 = errors;
      tick_n(3);
      credit_grant = credits_sent;          // hold back further credits
      auto_credit  = 1'b0;
      first = tx_q.size();
      cbase = rx_credit_cnt;
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         p = random_packet();
         sent.push_back(p);
         send_packet(p);
      end
      tick_n(20);
      if (tx_q.size() - first != OUT_CREDITS) begin
         errors++;
         $display("back_pressure: %0d packets sent on %0d credits",
                  tx_q.size() - first, OUT_CREDITS);
      end
      if (rx_credit_cnt - cbase != OUT_CREDITS) begin
         errors++;
         $display("back_pressure: %0d input credits returned while stalled",
                  rx_credit_cnt - cbase);
      end
      for (int k = OUT_CREDITS; k < FIFO_DEPTH; k++) begin
         credit_grant++;                    // release one at a time
         wait_tx(first + k + 1, "back_pressure");
      end
      tick_n(4);
      if (rx_credit_cnt - cbase != FIFO_DEPTH) begin
         errors++;
         $display("back_pressure: input credits not all returned after release");
      end
      compare_tx("back_pressure", first, sent, REMAP_NONE, '0, '0, '0);
      auto_credit = 1'b1;
      tick_n(4);
      report_test("back_pressure", err0);
   endtask

   task automatic drop_mode_test();
      int          err0;
      int          first;
      int          cbase;
      erx_data_t   sum;
      erx_data_t   rd;
      erx_packet_t p;
      erx_status_t exp;
      err0 = errors;
      sum = $urandom();                     // testdata seed
      mi_write(`ERX_CFG, 32'h1);
      mi_write(`ERX_TESTDATA, sum);
      mi_write(`ERX_STATUS, '0);
      first = tx_q.size();
      cbase = rx_credit_cnt;
      for (int i = 0; i < 6; i++) begin
         p = random_packet();
         sum = sum + p[PKT_DATA_LSB +: 32];
         send_packet(p);
      end
      wait_rx_credits(cbase + 6, "drop_mode");
      tick_n(4);
      if (tx_q.size() != first) begin
         errors++;
         $display("drop_mode: packet went out on tx in test mode");
      end
      mi_read(`ERX_STATUS, rd);
      exp = '0;
      exp[STAT_DROP] = 1'b1;
      check_status("drop_mode status", exp, rd[15:0]);
      mi_read(`ERX_TESTDATA, rd);
      check_data("drop_mode testdata", sum, rd);
      mi_write(`ERX_CFG, '0);
      report_test("drop_mode", err0);
   endtask

   //########################################################################
   // main sequence
   //########################################################################
   initial begin
      seed_init   = $urandom(SEED);
      nreset      = 1'b0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      rx_access   = 1'b0;
      rx_packet   = '0;
      gpio_datain = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 nreset = 1'b1;
      tick_n(2);
      reg_access_test();
      pass_through_test();
      remap_test();
      back_pressure_test();
      drop_mode_test();
      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               NUM_TESTS, failed_tests, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/erx_pkg.sv
design/erx_cfg_if.sv
design/erx_cfg.sv
design/erx_remap.sv
design/erx_dispatch.sv
design/erx_top.sv
tb/erx_checker.sv
tb/erx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the link receive testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module erx_tb \
   -Mdir obj_dir -o erx_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/erx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
